//--- rtl/id_pkg.sv
`default_nettype none

package id_pkg;

    ////////////////////////////////////////////////////////////
    // Field layout of the backplane straps
    ////////////////////////////////////////////////////////////

    localparam int NUM_FIELDS    = 3;
    localparam int FIELD_STATION = 0;
    localparam int FIELD_RACK    = 1;
    localparam int FIELD_SLOT    = 2;

    // Pin count per field, parity pin on top
    localparam int FIELD_RAW_W [NUM_FIELDS] = '{8, 4, 5};
    localparam int MAX_RAW_W = 8;

    // One zero padded slot per field
    typedef logic [NUM_FIELDS-1:0][MAX_RAW_W-1:0] id_snap_t;

    // Outcome of one field filter
    typedef struct packed {
        logic                 done;
        logic                 err;
        logic [MAX_RAW_W-1:0] value;
    } id_result_t;

    ////////////////////////////////////////////////////////////
    // AXI4-Lite host port
    ////////////////////////////////////////////////////////////

    // Master to slave
    typedef struct packed {
        logic        awvalid;
        logic [7:0]  awaddr;
        logic        wvalid;
        logic [31:0] wdata;
        logic        bready;
        logic        arvalid;
        logic [7:0]  araddr;
        logic        rready;
    } axil_req_t;

    // Slave to master
    typedef struct packed {
        logic        awready;
        logic        wready;
        logic        bvalid;
        logic [1:0]  bresp;
        logic        arready;
        logic        rvalid;
        logic [31:0] rdata;
        logic [1:0]  rresp;
    } axil_rsp_t;

    // Register map
    localparam logic [7:0] REG_STATUS = 8'h00;
    localparam logic [7:0] REG_ID     = 8'h04;
    localparam logic [7:0] REG_CTRL   = 8'h08;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire

//--- rtl/id_strap_sampler.sv
`timescale 1ns/100ps
`default_nettype none

module id_strap_sampler #(
    parameter int SAMPLE_DIV = 4
) (
    input  logic                                                  clk,
    input  logic                                                  rst_n,
    input  logic [id_pkg::FIELD_RAW_W[id_pkg::FIELD_STATION]-1:0] i_station,
    input  logic [id_pkg::FIELD_RAW_W[id_pkg::FIELD_RACK]-1:0]    i_rack,
    input  logic [id_pkg::FIELD_RAW_W[id_pkg::FIELD_SLOT]-1:0]    i_slot,
    output id_pkg::id_snap_t                                      o_snap,
    output logic                                                  o_sample
);

    localparam int STN_W = id_pkg::FIELD_RAW_W[id_pkg::FIELD_STATION];
    localparam int RCK_W = id_pkg::FIELD_RAW_W[id_pkg::FIELD_RACK];
    localparam int SLT_W = id_pkg::FIELD_RAW_W[id_pkg::FIELD_SLOT];
    localparam int PIN_W = STN_W + RCK_W + SLT_W;
    // At least one bit so SAMPLE_DIV of 1 still builds
    localparam int DIV_W = (SAMPLE_DIV > 1) ? $clog2(SAMPLE_DIV) : 1;

    logic [PIN_W-1:0]  pins_q1;
    logic [PIN_W-1:0]  pins_q2;
    logic [DIV_W-1:0]  div_q;
    logic              div_wrap;
    id_pkg::id_snap_t  snap_d;
    id_pkg::id_snap_t  snap_q;
    logic              sample_q;

    ////////////////////////////////////////////////////////////
    // Two flop synchronizer
    ////////////////////////////////////////////////////////////

    // Straps are static, all bits cross together
    always_ff @(posedge clk)
    begin
        pins_q1 <= {i_station, i_rack, i_slot};
        pins_q2 <= pins_q1;
    end

    ////////////////////////////////////////////////////////////
    // Sample prescaler
    ////////////////////////////////////////////////////////////

    assign div_wrap = (div_q == DIV_W'(SAMPLE_DIV - 1));

    // First strobe lands SAMPLE_DIV clocks out of reset
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            div_q    <= '0;
            sample_q <= 1'b0;
        end
        else
        begin
            sample_q <= div_wrap;
            if (div_wrap)
                div_q <= '0;
            else
                div_q <= div_q + 1'b1;
        end
    end

    // Unpack synchronized pins into padded slots
    always_comb
    begin
        snap_d = '0;
        snap_d[id_pkg::FIELD_STATION][STN_W-1:0] = pins_q2[PIN_W-1 -: STN_W];
        snap_d[id_pkg::FIELD_RACK][RCK_W-1:0]    = pins_q2[SLT_W +: RCK_W];
        snap_d[id_pkg::FIELD_SLOT][SLT_W-1:0]    = pins_q2[SLT_W-1:0];
    end

    // Snapshot updates on the same edge that raises the strobe
    always_ff @(posedge clk)
    begin
        if (div_wrap)
            snap_q <= snap_d;
    end

    assign o_snap   = snap_q;
    assign o_sample = sample_q;

endmodule

`default_nettype wire

//--- rtl/id_field_filter.sv
`timescale 1ns/100ps
`default_nettype none

module id_field_filter #(
    parameter int WIDTH           = 8,
    parameter int STABLE_COUNT    = 3,
    parameter int TIMEOUT_SAMPLES = 20,
    parameter bit PARITY_CHECK    = 1'b1
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic [id_pkg::MAX_RAW_W-1:0] i_raw,
    input  logic                         i_sample,
    input  logic                         i_restart,
    output id_pkg::id_result_t           o_result
);

    localparam int SAMP_W = $clog2(TIMEOUT_SAMPLES + 1);
    localparam int STAB_W = $clog2(STABLE_COUNT + 1);

    logic [WIDTH-1:0]             ref_q;
    logic [STAB_W-1:0]            stable_q;
    logic [SAMP_W-1:0]            samp_q;
    logic                         done_q;
    logic                         err_q;
    logic [id_pkg::MAX_RAW_W-1:0] value_q;

    logic [WIDTH-1:0]             field;
    logic                         first;
    logic                         active;
    logic                         match;
    logic [STAB_W-1:0]            stable_nxt;
    logic [SAMP_W-1:0]            samp_nxt;
    logic                         hit_stable;
    logic                         hit_timeout;
    logic                         finish;
    logic                         parity_bad;
    logic                         err_nxt;
    logic [id_pkg::MAX_RAW_W-1:0] value_nxt;

    ////////////////////////////////////////////////////////////
    // Next state of the counters
    ////////////////////////////////////////////////////////////

    assign field  = i_raw[WIDTH-1:0];
    // Sample count of zero means no reference yet
    assign first  = (samp_q == '0);
    assign active = !first && !done_q;
    assign match  = (field == ref_q);

    assign stable_nxt  = match ? stable_q + 1'b1 : '0;
    assign samp_nxt    = samp_q + 1'b1;
    assign hit_stable  = (stable_nxt == STAB_W'(STABLE_COUNT));
    assign hit_timeout = (samp_nxt == SAMP_W'(TIMEOUT_SAMPLES));
    assign finish      = i_sample && active && !i_restart && (hit_stable || hit_timeout);

    // Even parity over the whole field including the parity pin
    assign parity_bad = PARITY_CHECK && (^field);
    // Stable wins when both limits meet on one sample
    assign err_nxt    = !hit_stable || parity_bad;

    always_comb
    begin
        value_nxt = '0;
        if (!err_nxt)
            value_nxt[WIDTH-1:0] = ref_q;
    end

    ////////////////////////////////////////////////////////////
    // Control state
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            samp_q   <= '0;
            stable_q <= '0;
            done_q   <= 1'b0;
            err_q    <= 1'b0;
        end
        else if (i_restart)
        begin
            samp_q   <= '0;
            stable_q <= '0;
            done_q   <= 1'b0;
            err_q    <= 1'b0;
        end
        else if (i_sample && !done_q)
        begin
            if (first)
            begin
                samp_q   <= SAMP_W'(1);
                stable_q <= '0;
            end
            else
            begin
                samp_q   <= samp_nxt;
                stable_q <= stable_nxt;
                if (finish)
                begin
                    done_q <= 1'b1;
                    err_q  <= err_nxt;
                end
            end
        end
    end

    // Reference reloads on the first sample and on every mismatch
    always_ff @(posedge clk)
    begin
        if (i_sample && !done_q && !i_restart && (first || !match))
            ref_q <= field;
        if (finish)
            value_q <= value_nxt;
    end

    assign o_result.done  = done_q;
    assign o_result.err   = err_q;
    assign o_result.value = value_q;

    // Timeout must stop the sample counter
    a_samp_bound: assert property (@(posedge clk) disable iff (!rst_n)
        samp_q <= SAMP_W'(TIMEOUT_SAMPLES));

    // Only the register block may take done away
    a_done_hold: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(done_q) |-> $past(i_restart));

endmodule

`default_nettype wire

//--- rtl/id_axil_regs.sv
`timescale 1ns/100ps
`default_nettype none

module id_axil_regs (
    input  logic                                           clk,
    input  logic                                           rst_n,
    input  id_pkg::id_result_t [id_pkg::NUM_FIELDS-1:0]    i_results,
    input  id_pkg::axil_req_t                              i_axil,
    output id_pkg::axil_rsp_t                              o_axil,
    output logic                                           o_restart
);

    // ID bits per field without the parity pin
    localparam int STN_W = id_pkg::FIELD_RAW_W[id_pkg::FIELD_STATION] - 1;
    localparam int RCK_W = id_pkg::FIELD_RAW_W[id_pkg::FIELD_RACK] - 1;
    localparam int SLT_W = id_pkg::FIELD_RAW_W[id_pkg::FIELD_SLOT] - 1;

    logic                          wr_rdy_q;
    logic                          bvalid_q;
    logic [1:0]                    bresp_q;
    logic                          ar_rdy_q;
    logic                          rvalid_q;
    logic [31:0]                   rdata_q;
    logic [1:0]                    rresp_q;

    logic                          wr_fire;
    logic                          rd_fire;
    logic [id_pkg::NUM_FIELDS-1:0] field_done;
    logic [id_pkg::NUM_FIELDS-1:0] field_err;
    logic                          all_done;
    logic                          any_err;
    logic                          id_ok;
    logic [31:0]                   status_word;
    logic [31:0]                   id_word;
    logic [31:0]                   rd_word;
    logic [1:0]                    rd_resp;
    logic [1:0]                    wr_resp;

    ////////////////////////////////////////////////////////////
    // Register contents
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        for (int k = 0; k < id_pkg::NUM_FIELDS; k++)
        begin
            field_done[k] = i_results[k].done;
            field_err[k]  = i_results[k].err;
        end
    end

    assign all_done = &field_done;
    assign any_err  = |field_err;
    assign id_ok    = all_done && !any_err;

    always_comb
    begin
        status_word = '0;
        status_word[0] = all_done;
        status_word[1] = all_done && any_err;
        status_word[4 +: id_pkg::NUM_FIELDS] = field_err;
    end

    // Station at 0, rack at 8, slot at 16
    always_comb
    begin
        id_word = '0;
        if (id_ok)
        begin
            id_word[0 +: STN_W]  = i_results[id_pkg::FIELD_STATION].value[STN_W-1:0];
            id_word[8 +: RCK_W]  = i_results[id_pkg::FIELD_RACK].value[RCK_W-1:0];
            id_word[16 +: SLT_W] = i_results[id_pkg::FIELD_SLOT].value[SLT_W-1:0];
        end
    end

    // Read decode, CTRL reads back as zero
    always_comb
    begin
        rd_word = '0;
        rd_resp = id_pkg::RESP_OKAY;
        case (i_axil.araddr)
            id_pkg::REG_STATUS: rd_word = status_word;
            id_pkg::REG_ID:     rd_word = id_word;
            id_pkg::REG_CTRL:   rd_word = '0;
            default:            rd_resp = id_pkg::RESP_SLVERR;
        endcase
    end

    // Writes to read only registers are dropped silently
    always_comb
    begin
        case (i_axil.awaddr)
            id_pkg::REG_STATUS, id_pkg::REG_ID, id_pkg::REG_CTRL:
                wr_resp = id_pkg::RESP_OKAY;
            default:
                wr_resp = id_pkg::RESP_SLVERR;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Write channel
    ////////////////////////////////////////////////////////////

    assign wr_fire   = wr_rdy_q && i_axil.awvalid && i_axil.wvalid;
    assign o_restart = wr_fire && (i_axil.awaddr == id_pkg::REG_CTRL) && i_axil.wdata[0];

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_rdy_q <= 1'b0;
            bvalid_q <= 1'b0;
        end
        else
        begin
            // One cycle ready once both beats are offered
            wr_rdy_q <= !wr_rdy_q && !bvalid_q && i_axil.awvalid && i_axil.wvalid;
            if (wr_fire)
                bvalid_q <= 1'b1;
            else if (i_axil.bready)
                bvalid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (wr_fire)
            bresp_q <= wr_resp;
    end

    ////////////////////////////////////////////////////////////
    // Read channel
    ////////////////////////////////////////////////////////////

    assign rd_fire = ar_rdy_q && i_axil.arvalid;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            ar_rdy_q <= 1'b0;
            rvalid_q <= 1'b0;
        end
        else
        begin
            // No new address while a response is pending
            ar_rdy_q <= !ar_rdy_q && !rvalid_q && i_axil.arvalid;
            if (rd_fire)
                rvalid_q <= 1'b1;
            else if (i_axil.rready)
                rvalid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rd_fire)
        begin
            rdata_q <= rd_word;
            rresp_q <= rd_resp;
        end
    end

    assign o_axil.awready = wr_rdy_q;
    assign o_axil.wready  = wr_rdy_q;
    assign o_axil.bvalid  = bvalid_q;
    assign o_axil.bresp   = bresp_q;
    assign o_axil.arready = ar_rdy_q;
    assign o_axil.rvalid  = rvalid_q;
    assign o_axil.rdata   = rdata_q;
    assign o_axil.rresp   = rresp_q;

    // Responses survive back-pressure
    a_b_hold: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid_q && !i_axil.bready |=> bvalid_q && $stable(bresp_q));

    a_r_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid_q && !i_axil.rready |=> rvalid_q && $stable(rdata_q) && $stable(rresp_q));

endmodule

`default_nettype wire

//--- rtl/id_read_top.sv
`timescale 1ns/100ps
`default_nettype none

module id_read_top #(
    parameter int SAMPLE_DIV      = 4,
    parameter int STABLE_COUNT    = 3,
    parameter int TIMEOUT_SAMPLES = 20,
    parameter bit PARITY_CHECK    = 1'b1
) (
    input  logic                                                  clk,
    input  logic                                                  rst_n,
    input  logic [id_pkg::FIELD_RAW_W[id_pkg::FIELD_STATION]-1:0] i_station,
    input  logic [id_pkg::FIELD_RAW_W[id_pkg::FIELD_RACK]-1:0]    i_rack,
    input  logic [id_pkg::FIELD_RAW_W[id_pkg::FIELD_SLOT]-1:0]    i_slot,
    input  id_pkg::axil_req_t                                     i_axil,
    output id_pkg::axil_rsp_t                                     o_axil
);

    id_pkg::id_snap_t                                snap;
    logic                                            sample;
    logic                                            restart;
    id_pkg::id_result_t [id_pkg::NUM_FIELDS-1:0]     results;

    // Pin synchronizer and sample strobe
    id_strap_sampler #(
        .SAMPLE_DIV (SAMPLE_DIV)
    ) u_sampler (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_station (i_station),
        .i_rack    (i_rack),
        .i_slot    (i_slot),
        .o_snap    (snap),
        .o_sample  (sample)
    );

    ////////////////////////////////////////////////////////////
    // One filter per strap field
    ////////////////////////////////////////////////////////////

    for (genvar k = 0; k < id_pkg::NUM_FIELDS; k++)
    begin : g_field
        id_field_filter #(
            .WIDTH           (id_pkg::FIELD_RAW_W[k]),
            .STABLE_COUNT    (STABLE_COUNT),
            .TIMEOUT_SAMPLES (TIMEOUT_SAMPLES),
            .PARITY_CHECK    (PARITY_CHECK)
        ) u_filter (
            .clk       (clk),
            .rst_n     (rst_n),
            .i_raw     (snap[k]),
            .i_sample  (sample),
            .i_restart (restart),
            .o_result  (results[k])
        );
    end

    // Host registers and restart source
    id_axil_regs u_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_results (results),
        .i_axil    (i_axil),
        .o_axil    (o_axil),
        .o_restart (restart)
    );

endmodule

`default_nettype wire

//--- bench/id_read_tb.sv
`timescale 1ns/100ps
`default_nettype none

module id_read_tb;

    localparam int SAMPLE_DIV      = 4;
    localparam int STABLE_COUNT    = 3;
    localparam int TIMEOUT_SAMPLES = 20;
    localparam bit PARITY_CHECK    = 1'b1;

    // Per wait bound for one AXI beat
    localparam int WAIT_LIMIT = 16;
    // Bound for a full filter pass, in clocks
    localparam int POLL_LIMIT = (TIMEOUT_SAMPLES + 4) * SAMPLE_DIV + 10;

    logic               clk = 1'b0;
    logic               rst_n;
    logic [7:0]         stn;
    logic [3:0]         rck;
    logic [4:0]         slt;
    id_pkg::axil_req_t  req;
    id_pkg::axil_rsp_t  rsp;
    int                 seed = 32'h77b8_22a5;
    int                 cycle = 0;

    id_read_top #(
        .SAMPLE_DIV      (SAMPLE_DIV),
        .STABLE_COUNT    (STABLE_COUNT),
        .TIMEOUT_SAMPLES (TIMEOUT_SAMPLES),
        .PARITY_CHECK    (PARITY_CHECK)
    ) dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_station (stn),
        .i_rack    (rck),
        .i_slot    (slt),
        .i_axil    (req),
        .o_axil    (rsp)
    );

    // 40 ns clock period
    always #20 clk = ~clk;

    // Free running clock count for poll bounds
    always @(posedge clk)
        cycle <= cycle + 1;

    ////////////////////////////////////////////////////////////
    // Failure reporting and checks
    ////////////////////////////////////////////////////////////

    task automatic abort_run(input string why);
        $display("%s at %0t ns", why, $time);
        $display("RESULT: FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp)
        else
        begin
            $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    // Write address and data ready always move together
    ready_pair: assert property (@(posedge clk) disable iff (!rst_n)
        rsp.awready == rsp.wready)
        else abort_run("awready and wready differ");

    // No new read address while a response waits
    no_read_overlap: assert property (@(posedge clk) disable iff (!rst_n)
        !(rsp.arready && rsp.rvalid))
        else abort_run("arready high while a read response is pending");

    ////////////////////////////////////////////////////////////
    // Expected values from the field rules
    ////////////////////////////////////////////////////////////

    // Top pin of a w wide field made even parity
    function automatic logic [7:0] even_field(input logic [7:0] raw, input int w);
        logic [7:0] top;
        logic [7:0] v;
        top = 8'd1 << (w - 1);
        v = raw & (top - 8'd1);
        if (^v)
            v = v | top;
        return v;
    endfunction

    // Parity pins dropped and fields placed at bits 0, 8 and 16
    function automatic logic [31:0] expected_id(input logic [7:0] s, input logic [3:0] r,
                                                input logic [4:0] t);
        logic [31:0] id;
        id = '0;
        id[6:0]   = s[6:0];
        id[10:8]  = r[2:0];
        id[19:16] = t[3:0];
        return id;
    endfunction

    task automatic pick_even_pins();
        logic [31:0] r;
        logic [7:0]  f;
        r = $random(seed);
        stn = even_field(r[7:0], 8);
        f = even_field(r[15:8], 4);
        rck = f[3:0];
        f = even_field(r[23:16], 5);
        slt = f[4:0];
    endtask

    ////////////////////////////////////////////////////////////
    // AXI4-Lite master tasks called 2 ns after an edge
    ////////////////////////////////////////////////////////////

    task automatic read_reg(input logic [7:0] addr, input int hold,
                            output logic [31:0] data, output logic [1:0] resp);
        int n;
        req.arvalid = 1'b1;
        req.araddr  = addr;
        n = 0;
        while (rsp.arready !== 1'b1)
        begin
            if (n == WAIT_LIMIT)
                abort_run("timeout waiting for arready");
            @(posedge clk);
            #2;
            n++;
        end
        // Address beat on this edge
        @(posedge clk);
        #2;
        req.arvalid = 1'b0;
        n = 0;
        while (rsp.rvalid !== 1'b1)
        begin
            if (n == WAIT_LIMIT)
                abort_run("timeout waiting for rvalid");
            @(posedge clk);
            #2;
            n++;
        end
        data = rsp.rdata;
        resp = rsp.rresp;
        // Response must sit still under back-pressure
        for (int k = 0; k < hold; k++)
        begin
            @(posedge clk);
            #2;
            check_eq("rvalid", 32'(rsp.rvalid), 32'd1);
            check_eq("rdata", rsp.rdata, data);
            check_eq("rresp", 32'(rsp.rresp), 32'(resp));
        end
        req.rready = 1'b1;
        @(posedge clk);
        #2;
        req.rready = 1'b0;
        check_eq("rvalid", 32'(rsp.rvalid), 32'd0);
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
        int n;
        req.awvalid = 1'b1;
        req.awaddr  = addr;
        req.wvalid  = 1'b1;
        req.wdata   = data;
        n = 0;
        while (rsp.awready !== 1'b1)
        begin
            if (n == WAIT_LIMIT)
                abort_run("timeout waiting for awready");
            @(posedge clk);
            #2;
            n++;
        end
        @(posedge clk);
        #2;
        req.awvalid = 1'b0;
        req.wvalid  = 1'b0;
        n = 0;
        while (rsp.bvalid !== 1'b1)
        begin
            if (n == WAIT_LIMIT)
                abort_run("timeout waiting for bvalid");
            @(posedge clk);
            #2;
            n++;
        end
        resp = rsp.bresp;
        // B response held one clock with bready low
        @(posedge clk);
        #2;
        check_eq("bvalid", 32'(rsp.bvalid), 32'd1);
        check_eq("bresp", 32'(rsp.bresp), 32'(resp));
        req.bready = 1'b1;
        @(posedge clk);
        #2;
        req.bready = 1'b0;
        check_eq("bvalid", 32'(rsp.bvalid), 32'd0);
    endtask

    // Poll STATUS until all fields report done
    task automatic poll_done(output logic [31:0] status);
        int         start;
        logic [1:0] resp;
        start  = cycle;
        status = '0;
        while (status[0] !== 1'b1)
        begin
            if (cycle - start > POLL_LIMIT)
                abort_run("timeout waiting for STATUS done");
            read_reg(id_pkg::REG_STATUS, 0, status, resp);
            check_eq("STATUS rresp", 32'(resp), 32'(id_pkg::RESP_OKAY));
        end
    endtask

    task automatic restart_read();
        logic [1:0] resp;
        write_reg(id_pkg::REG_CTRL, 32'd1, resp);
        check_eq("CTRL bresp", 32'(resp), 32'(id_pkg::RESP_OKAY));
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    initial
    begin
        logic [31:0] status;
        logic [31:0] data;
        logic [31:0] want_id;
        logic [1:0]  resp;
        logic [7:0]  cnt;
        rst_n = 1'b0;
        req   = '0;
        pick_even_pins();
        repeat (4) @(posedge clk);
        #2;
        rst_n = 1'b1;

        // Quiet bus out of reset
        check_eq("awready", 32'(rsp.awready), 32'd0);
        check_eq("wready", 32'(rsp.wready), 32'd0);
        check_eq("bvalid", 32'(rsp.bvalid), 32'd0);
        check_eq("arready", 32'(rsp.arready), 32'd0);
        check_eq("rvalid", 32'(rsp.rvalid), 32'd0);
        read_reg(id_pkg::REG_STATUS, 0, status, resp);
        check_eq("STATUS done", 32'(status[0]), 32'd0);

        // Steady straps, good parity
        want_id = expected_id(stn, rck, slt);
        poll_done(status);
        check_eq("STATUS", status, 32'h0000_0001);
        read_reg(id_pkg::REG_ID, 0, data, resp);
        check_eq("ID", data, want_id);

        // Rack parity pin flipped
        pick_even_pins();
        rck = rck ^ 4'b1000;
        restart_read();
        poll_done(status);
        check_eq("STATUS", status, 32'h0000_0023);
        read_reg(id_pkg::REG_ID, 0, data, resp);
        check_eq("ID", data, 32'd0);

        // New value on every sample until timeout
        cnt = 8'd0;
        stn = cnt;
        rck = cnt[3:0];
        slt = cnt[4:0];
        restart_read();
        repeat (TIMEOUT_SAMPLES + 2)
        begin
            repeat (SAMPLE_DIV) @(posedge clk);
            #2;
            cnt = cnt + 8'd1;
            stn = cnt;
            rck = cnt[3:0];
            slt = cnt[4:0];
        end
        poll_done(status);
        check_eq("STATUS", status, 32'h0000_0073);
        read_reg(id_pkg::REG_ID, 0, data, resp);
        check_eq("ID", data, 32'd0);

        // Restart with fresh steady straps
        pick_even_pins();
        want_id = expected_id(stn, rck, slt);
        restart_read();
        read_reg(id_pkg::REG_STATUS, 0, status, resp);
        check_eq("STATUS done", 32'(status[0]), 32'd0);
        poll_done(status);
        check_eq("STATUS", status, 32'h0000_0001);
        read_reg(id_pkg::REG_ID, 0, data, resp);
        check_eq("ID", data, want_id);

        // Unmapped read and R channel back-pressure
        read_reg(8'h0C, 0, data, resp);
        check_eq("rresp", 32'(resp), 32'(id_pkg::RESP_SLVERR));
        check_eq("rdata", data, 32'd0);
        read_reg(id_pkg::REG_ID, 5, data, resp);
        check_eq("rresp", 32'(resp), 32'(id_pkg::RESP_OKAY));
        check_eq("ID", data, want_id);

        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
rtl/id_pkg.sv
rtl/id_strap_sampler.sv
rtl/id_field_filter.sv
rtl/id_axil_regs.sv
rtl/id_read_top.sv
bench/id_read_tb.sv

//--- run.sh
#!/bin/sh
# Build the ID reader testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module id_read_tb -o id_read_sim \
    || { echo "build failed"; exit 1; }

out=$(./obj_dir/id_read_sim 2>&1)
printf '%s\n' "$out"

printf '%s\n' "$out" | grep -qx 'RESULT: PASS' \
    && echo "simulation passed" && exit 0 \
    || { echo "simulation failed"; exit 1; }
